// ==== lsu_pkg.sv ====
// ################################################
// shared definitions for the tile load/store unit
// address map, operation encodings and the
// structs carried between host, unit and network
// ################################################

package lsu_pkg;

  localparam int data_width_c      = 32;
  localparam int mask_width_c      = 4;
  localparam int dmem_addr_width_c = 10;
  localparam int reg_addr_width_c  = 5;
  localparam int imm_width_c       = 12;
  localparam int tg_x_width_c      = 6;
  localparam int tg_y_width_c      = 5;

  // tile-group address layout
  localparam logic [2:0] tile_group_tag_c = 3'b001;
  localparam int tg_tag_lsb_c        = 29;
  localparam int tg_y_lsb_c          = 24;
  localparam int tg_x_lsb_c          = 18;
  // plain local space is the low 4 KB
  localparam int plain_local_width_c = 12;

  typedef enum logic [3:0] {
    mem_lw,
    mem_lh,
    mem_lhu,
    mem_lb,
    mem_lbu,
    mem_sw,
    mem_sh,
    mem_sb,
    mem_lr,
    mem_amoswap,
    mem_amoadd
  } mem_op_e;

  typedef enum logic [0:0] {
    amo_swap,
    amo_add
  } amo_type_e;

  typedef struct packed {
    mem_op_e                     op;
    logic [data_width_c-1:0]     rs1;
    logic [data_width_c-1:0]     rs2;
    logic [reg_addr_width_c-1:0] rd;
    logic [imm_width_c-1:0]      offset;
  } mem_op_s;

  typedef struct packed {
    logic       is_unsigned;
    logic       is_byte;
    logic       is_half;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    logic                        write_not_read;
    logic                        is_amo;
    amo_type_e                   amo_type;
    logic [mask_width_c-1:0]     mask;
    load_info_s                  load_info;
    logic [reg_addr_width_c-1:0] reg_id;
    logic [data_width_c-1:0]     data;
    logic [data_width_c-1:0]     addr;
  } remote_req_s;

endpackage

// ==== lsu.sv ====
// ################################################
// address path of the load/store unit
// computes the effective address, steers it to
// local memory or the network, and builds store
// lanes, byte mask and the remote request
// ################################################

`timescale 1ns/1ps

module lsu (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  lsu_pkg::mem_op_s                       op_i,
  input  logic [lsu_pkg::tg_x_width_c-1:0]       tg_x_cord_i,
  input  logic [lsu_pkg::tg_y_width_c-1:0]       tg_y_cord_i,
  output logic                                   is_local_o,
  output logic                                   remote_valid_o,
  output logic                                   dmem_w_o,
  output logic [lsu_pkg::dmem_addr_width_c-1:0]  dmem_addr_o,
  output logic [lsu_pkg::data_width_c-1:0]       dmem_data_o,
  output logic [lsu_pkg::mask_width_c-1:0]       dmem_mask_o,
  output logic                                   reserve_o,
  output lsu_pkg::remote_req_s                   remote_data_o,
  output lsu_pkg::load_info_s                    load_info_o
);

  logic [lsu_pkg::data_width_c-1:0] mem_addr;
  logic [lsu_pkg::data_width_c-1:0] store_data;
  logic [lsu_pkg::mask_width_c-1:0] store_mask;
  logic is_byte;
  logic is_half;
  logic is_unsigned;
  logic is_store;
  logic is_amo;
  logic is_lr;
  logic is_tile_group_local;
  logic is_plain_local;
  logic is_local_addr;

  assign mem_addr = op_i.rs1 + {{(lsu_pkg::data_width_c - lsu_pkg::imm_width_c)
                                 {op_i.offset[lsu_pkg::imm_width_c-1]}}, op_i.offset};

  // opcode decode
  always_comb begin
    is_byte     = (op_i.op == lsu_pkg::mem_lb) || (op_i.op == lsu_pkg::mem_lbu) ||
                  (op_i.op == lsu_pkg::mem_sb);
    is_half     = (op_i.op == lsu_pkg::mem_lh) || (op_i.op == lsu_pkg::mem_lhu) ||
                  (op_i.op == lsu_pkg::mem_sh);
    is_unsigned = (op_i.op == lsu_pkg::mem_lbu) || (op_i.op == lsu_pkg::mem_lhu);
    is_store    = (op_i.op == lsu_pkg::mem_sw) || (op_i.op == lsu_pkg::mem_sh) ||
                  (op_i.op == lsu_pkg::mem_sb);
    is_amo      = (op_i.op == lsu_pkg::mem_amoswap) || (op_i.op == lsu_pkg::mem_amoadd);
    is_lr       = (op_i.op == lsu_pkg::mem_lr);
  end

  // replicate store lanes so the mask picks the live ones
  always_comb begin
    if (is_byte) begin
      store_data = {4{op_i.rs2[7:0]}};
      store_mask = 4'b0001 << mem_addr[1:0];
    end else if (is_half) begin
      store_data = {2{op_i.rs2[15:0]}};
      store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
    end else begin
      // word stores and amo
      store_data = op_i.rs2;
      store_mask = 4'b1111;
    end
  end

  // tile-group form naming our own x/y
  assign is_tile_group_local =
    (mem_addr[lsu_pkg::data_width_c-1:lsu_pkg::tg_tag_lsb_c] == lsu_pkg::tile_group_tag_c) &&
    (mem_addr[lsu_pkg::tg_y_lsb_c +: lsu_pkg::tg_y_width_c] == tg_y_cord_i) &&
    (mem_addr[lsu_pkg::tg_x_lsb_c +: lsu_pkg::tg_x_width_c] == tg_x_cord_i);

  assign is_plain_local = (mem_addr[lsu_pkg::data_width_c-1:lsu_pkg::plain_local_width_c] == '0);
  assign is_local_addr  = is_plain_local || is_tile_group_local;

  // amo always goes out since the far side executes it
  assign is_local_o     = is_local_addr && !is_amo;
  assign remote_valid_o = !is_local_addr || is_amo;

  assign dmem_w_o    = is_store;
  assign dmem_addr_o = mem_addr[2 +: lsu_pkg::dmem_addr_width_c];
  assign dmem_data_o = store_data;
  assign dmem_mask_o = store_mask;
  assign reserve_o   = is_lr && is_local_addr;

  always_comb begin
    load_info_o.is_unsigned = is_unsigned;
    load_info_o.is_byte     = is_byte;
    load_info_o.is_half     = is_half;
    load_info_o.part_sel    = mem_addr[1:0];

    remote_data_o.write_not_read = is_store;
    remote_data_o.is_amo         = is_amo;
    remote_data_o.amo_type       = (op_i.op == lsu_pkg::mem_amoadd) ? lsu_pkg::amo_add
                                                                    : lsu_pkg::amo_swap;
    remote_data_o.mask           = store_mask;
    remote_data_o.load_info      = load_info_o;
    remote_data_o.reg_id         = op_i.rd;
    remote_data_o.data           = store_data;
    remote_data_o.addr           = mem_addr;
  end

  // the held operation must respect the address map while it is in flight
  amo_not_local_a : assert property (@(posedge clk_i) disable iff (!reset_i)
    is_amo |-> !is_local_addr)
    else $error("amo aimed at local data memory, addr %h", mem_addr);

  lr_not_remote_a : assert property (@(posedge clk_i) disable iff (!reset_i)
    is_lr |-> is_local_addr)
    else $error("load-reserved aimed at a remote address, addr %h", mem_addr);

endmodule

// ==== lsu_dmem.sv ====
// ################################################
// local data memory of the tile, one word wide
// byte-masked writes and a registered read per
// strobe, plus the single load reservation
// ################################################

`timescale 1ns/1ps

module lsu_dmem (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  strobe_i,
  input  logic                                  w_i,
  input  logic [lsu_pkg::dmem_addr_width_c-1:0] addr_i,
  input  logic [lsu_pkg::data_width_c-1:0]      data_i,
  input  logic [lsu_pkg::mask_width_c-1:0]      mask_i,
  input  logic                                  reserve_i,
  output logic [lsu_pkg::data_width_c-1:0]      rdata_o,
  output logic                                  reserve_valid_o
);

  logic [lsu_pkg::data_width_c-1:0] mem_q [0:(1 << lsu_pkg::dmem_addr_width_c)-1];
  logic [lsu_pkg::dmem_addr_width_c-1:0] res_addr_q;

  // storage and read port
  always_ff @(posedge clk_i) begin
    if (strobe_i) begin
      if (w_i) begin
        for (int i = 0; i < lsu_pkg::mask_width_c; i++) begin
          if (mask_i[i]) begin
            mem_q[addr_i][8*i +: 8] <= data_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem_q[addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (strobe_i && reserve_i) begin
      res_addr_q <= addr_i;
    end
  end

  // reservation flag, cleared by any store to the reserved word
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reserve_valid_o <= 1'b0;
    end else if (strobe_i) begin
      if (reserve_i) begin
        reserve_valid_o <= 1'b1;
      end else if (w_i && (addr_i == res_addr_q)) begin
        reserve_valid_o <= 1'b0;
      end
    end
  end

endmodule

// ==== load_align.sv ====
// ################################################
// load return aligner
// moves the addressed byte or half down to bit 0
// and sign- or zero-extends it, for local and
// remote returns alike
// ################################################

`timescale 1ns/1ps

module load_align (
  input  logic [lsu_pkg::data_width_c-1:0] word_i,
  input  lsu_pkg::load_info_s              info_i,
  output logic [lsu_pkg::data_width_c-1:0] data_o
);

  logic [lsu_pkg::data_width_c-1:0] shifted;
  logic                             fill;

  assign shifted = word_i >> {info_i.part_sel, 3'b000};

  always_comb begin
    if (info_i.is_byte) begin
      fill   = !info_i.is_unsigned && shifted[7];
      data_o = {{24{fill}}, shifted[7:0]};
    end else if (info_i.is_half) begin
      fill   = !info_i.is_unsigned && shifted[15];
      data_o = {{16{fill}}, shifted[15:0]};
    end else begin
      // full word, untouched
      fill   = 1'b0;
      data_o = word_i;
    end
  end

endmodule

// ==== lsu_ctrl.sv ====
// ################################################
// sequencer of the load/store unit
// runs the host and network four-phase handshakes,
// holds the operation while it is serviced and
// registers the returned load data
// ################################################

`timescale 1ns/1ps

module lsu_ctrl (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              op_req_i,
  input  lsu_pkg::mem_op_s                  op_i,
  input  logic                              is_local_i,
  input  logic                              remote_valid_i,
  input  logic                              remote_ack_i,
  input  logic [lsu_pkg::data_width_c-1:0]  remote_rdata_i,
  input  logic [lsu_pkg::data_width_c-1:0]  dmem_rdata_i,
  input  logic [lsu_pkg::data_width_c-1:0]  aligned_i,
  output logic                              op_ack_o,
  output lsu_pkg::mem_op_s                  op_o,
  output logic                              dmem_strobe_o,
  output logic                              remote_req_o,
  output logic [lsu_pkg::data_width_c-1:0]  raw_word_o,
  output logic [lsu_pkg::data_width_c-1:0]  load_data_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_latch,
    st_local_access,
    st_local_capture,
    st_remote_req,
    st_remote_release,
    st_ack,
    st_wait_release
  } state_e;

  state_e                           state_q;
  logic [lsu_pkg::data_width_c-1:0] remote_word_q;
  logic                             is_store;

  assign is_store = (op_o.op == lsu_pkg::mem_sw) || (op_o.op == lsu_pkg::mem_sh) ||
                    (op_o.op == lsu_pkg::mem_sb);

  assign dmem_strobe_o = (state_q == st_local_access);
  assign raw_word_o    = is_local_i ? dmem_rdata_i : remote_word_q;

  // operation and network word are held until the next transfer
  always_ff @(posedge clk_i) begin
    if ((state_q == st_idle) && op_req_i) begin
      op_o <= op_i;
    end
    if ((state_q == st_remote_req) && remote_req_o && remote_ack_i) begin
      remote_word_q <= remote_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_q      <= st_idle;
      op_ack_o     <= 1'b0;
      remote_req_o <= 1'b0;
      load_data_o  <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          // ack drops one cycle after the host released
          op_ack_o <= 1'b0;
          if (op_req_i) begin
            state_q <= st_latch;
          end
        end
        st_latch: begin
          state_q <= remote_valid_i ? st_remote_req : st_local_access;
        end
        st_local_access: begin
          state_q <= st_local_capture;
        end
        st_remote_req: begin
          if (!remote_req_o) begin
            remote_req_o <= 1'b1;
          end else if (remote_ack_i) begin
            remote_req_o <= 1'b0;
            state_q      <= st_remote_release;
          end
        end
        st_remote_release: begin
          if (!remote_ack_i) begin
            state_q <= st_ack;
          end
        end
        st_local_capture, st_ack: begin
          load_data_o <= is_store ? '0 : aligned_i;
          op_ack_o    <= 1'b1;
          state_q     <= st_wait_release;
        end
        st_wait_release: begin
          if (!op_req_i) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // network side may stall for any number of cycles
  remote_req_hold_a : assert property (@(posedge clk_i) disable iff (!reset_i)
    remote_req_o && !remote_ack_i |=> remote_req_o)
    else $error("remote request dropped before the network acknowledged");

endmodule

// ==== lsu_tile.sv ====
// ################################################
// top level of the tile load/store subsystem
// host operation port in, network request port
// out; wires the sequencer, address unit, local
// memory and load aligner together
// ################################################

`timescale 1ns/1ps

module lsu_tile (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              op_req_i,
  input  lsu_pkg::mem_op_s                  op_i,
  input  logic [lsu_pkg::tg_x_width_c-1:0]  tg_x_cord_i,
  input  logic [lsu_pkg::tg_y_width_c-1:0]  tg_y_cord_i,
  input  logic                              remote_ack_i,
  input  logic [lsu_pkg::data_width_c-1:0]  remote_rdata_i,
  output logic                              op_ack_o,
  output logic [lsu_pkg::data_width_c-1:0]  load_data_o,
  output logic                              remote_req_o,
  output lsu_pkg::remote_req_s              remote_data_o,
  output logic                              reserve_valid_o
);

  lsu_pkg::mem_op_s                      op_q;
  lsu_pkg::load_info_s                   load_info;
  logic                                  is_local;
  logic                                  remote_valid;
  logic                                  dmem_strobe;
  logic                                  dmem_w;
  logic [lsu_pkg::dmem_addr_width_c-1:0] dmem_addr;
  logic [lsu_pkg::data_width_c-1:0]      dmem_data;
  logic [lsu_pkg::mask_width_c-1:0]      dmem_mask;
  logic [lsu_pkg::data_width_c-1:0]      dmem_rdata;
  logic                                  reserve;
  logic [lsu_pkg::data_width_c-1:0]      raw_word;
  logic [lsu_pkg::data_width_c-1:0]      aligned;

  lsu_ctrl u_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .op_req_i       (op_req_i),
    .op_i           (op_i),
    .is_local_i     (is_local),
    .remote_valid_i (remote_valid),
    .remote_ack_i   (remote_ack_i),
    .remote_rdata_i (remote_rdata_i),
    .dmem_rdata_i   (dmem_rdata),
    .aligned_i      (aligned),
    .op_ack_o       (op_ack_o),
    .op_o           (op_q),
    .dmem_strobe_o  (dmem_strobe),
    .remote_req_o   (remote_req_o),
    .raw_word_o     (raw_word),
    .load_data_o    (load_data_o)
  );

  lsu u_lsu (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .op_i           (op_q),
    .tg_x_cord_i    (tg_x_cord_i),
    .tg_y_cord_i    (tg_y_cord_i),
    .is_local_o     (is_local),
    .remote_valid_o (remote_valid),
    .dmem_w_o       (dmem_w),
    .dmem_addr_o    (dmem_addr),
    .dmem_data_o    (dmem_data),
    .dmem_mask_o    (dmem_mask),
    .reserve_o      (reserve),
    .remote_data_o  (remote_data_o),
    .load_info_o    (load_info)
  );

  lsu_dmem u_dmem (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .strobe_i        (dmem_strobe),
    .w_i             (dmem_w),
    .addr_i          (dmem_addr),
    .data_i          (dmem_data),
    .mask_i          (dmem_mask),
    .reserve_i       (reserve),
    .rdata_o         (dmem_rdata),
    .reserve_valid_o (reserve_valid_o)
  );

  load_align u_align (
    .word_i (raw_word),
    .info_i (load_info),
    .data_o (aligned)
  );

endmodule

// ==== lsu_tile_tb.sv ====
// ##################################################
// testbench for the tile load/store subsystem
// replays operation vectors from lsu_testdata.txt,
// plays the network with a random ack delay and
// checks results, path, timing and reservation
// ##################################################

`timescale 1ns/1ps

module lsu_tile_tb;

  localparam int timeout_c = 200;

  logic                                 clk_i;
  logic                                 reset_i;
  logic                                 op_req_i;
  lsu_pkg::mem_op_s                     op_i;
  logic [lsu_pkg::tg_x_width_c-1:0]     tg_x_cord_i;
  logic [lsu_pkg::tg_y_width_c-1:0]     tg_y_cord_i;
  logic                                 remote_ack_i;
  logic [lsu_pkg::data_width_c-1:0]     remote_rdata_i;
  logic                                 op_ack_o;
  logic [lsu_pkg::data_width_c-1:0]     load_data_o;
  logic                                 remote_req_o;
  lsu_pkg::remote_req_s                 remote_data_o;
  logic                                 reserve_valid_o;

  int          error_count;
  int          timeout_count;
  int          vector_count;
  logic [31:0] rng_state;
  // fields of the current vector
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [31:0] offset;
  logic [31:0] rd;
  logic [31:0] exp_path;
  logic [31:0] exp_addr;
  logic [31:0] exp_mask;
  logic [31:0] exp_data;
  logic [31:0] net_rdata;
  logic [31:0] exp_load;
  logic [31:0] exp_res;
  logic        exp_wnr;
  logic        exp_amo;
  logic        exp_amo_add;
  // unsigned, byte and half flags of the load info
  logic [2:0]  exp_flags;

  lsu_tile dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .op_req_i        (op_req_i),
    .op_i            (op_i),
    .tg_x_cord_i     (tg_x_cord_i),
    .tg_y_cord_i     (tg_y_cord_i),
    .remote_ack_i    (remote_ack_i),
    .remote_rdata_i  (remote_rdata_i),
    .op_ack_o        (op_ack_o),
    .load_data_o     (load_data_o),
    .remote_req_o    (remote_req_o),
    .remote_data_o   (remote_data_o),
    .reserve_valid_o (reserve_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [95:0] actual,
                             input logic [95:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout at %0t ns: %s", $time, what);
  endtask

  // mnemonic to opcode plus the remote flags this kind must carry
  task automatic decode_kind(input logic [63:0] kind, output lsu_pkg::mem_op_e op_code,
                             output logic ok);
    ok      = 1'b1;
    op_code = lsu_pkg::mem_lw;
    case (kind)
      "lw":      op_code = lsu_pkg::mem_lw;
      "lh":      op_code = lsu_pkg::mem_lh;
      "lhu":     op_code = lsu_pkg::mem_lhu;
      "lb":      op_code = lsu_pkg::mem_lb;
      "lbu":     op_code = lsu_pkg::mem_lbu;
      "sw":      op_code = lsu_pkg::mem_sw;
      "sh":      op_code = lsu_pkg::mem_sh;
      "sb":      op_code = lsu_pkg::mem_sb;
      "lr":      op_code = lsu_pkg::mem_lr;
      "amoswap": op_code = lsu_pkg::mem_amoswap;
      "amoadd":  op_code = lsu_pkg::mem_amoadd;
      default:   ok = 1'b0;
    endcase
    exp_wnr      = (kind == "sw") || (kind == "sh") || (kind == "sb");
    exp_amo      = (kind == "amoswap") || (kind == "amoadd");
    exp_amo_add  = (kind == "amoadd");
    exp_flags[2] = (kind == "lhu") || (kind == "lbu");
    exp_flags[1] = (kind == "lb") || (kind == "lbu") || (kind == "sb");
    exp_flags[0] = (kind == "lh") || (kind == "lhu") || (kind == "sh");
  endtask

  // network side of one remote transfer once remote_req_o is seen
  task automatic serve_network();
    lsu_pkg::remote_req_s held;
    int unsigned          delay;
    int                   i;
    int                   n;
    held = remote_data_o;
    check_value("remote_data_o.addr", held.addr, exp_addr);
    check_value("remote_data_o.mask", held.mask, exp_mask);
    check_value("remote_data_o.data", held.data, exp_data);
    check_value("remote_data_o.write_not_read", held.write_not_read, exp_wnr);
    check_value("remote_data_o.is_amo", held.is_amo, exp_amo);
    check_value("remote_data_o.reg_id", held.reg_id, rd[lsu_pkg::reg_addr_width_c-1:0]);
    check_value("remote_data_o.load_info", held.load_info, {exp_flags, exp_addr[1:0]});
    if (exp_amo) begin
      check_value("remote_data_o.amo_type", held.amo_type, exp_amo_add);
    end
    rng_state = xorshift32(rng_state);
    delay     = rng_state % 6;
    // request has to hold still while the network stalls
    for (i = 0; i < delay; i++) begin
      @(negedge clk_i);
      check_value("remote_data_o", remote_data_o, held);
      check_value("remote_req_o", remote_req_o, 1'b1);
      check_value("op_ack_o", op_ack_o, 1'b0);
    end
    remote_ack_i   = 1'b1;
    remote_rdata_i = net_rdata;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (remote_req_o && n < timeout_c);
    if (remote_req_o) begin
      report_timeout("remote_req_o stayed high after remote_ack_i");
    end
    remote_ack_i   = 1'b0;
    remote_rdata_i = '0;
    check_value("op_ack_o", op_ack_o, 1'b0);
  endtask

  // one host transfer started on a falling edge
  task automatic run_op(input lsu_pkg::mem_op_s op);
    int   n;
    int   net_done;
    logic went_remote;
    op_i        = op;
    op_req_i    = 1'b1;
    n           = 0;
    net_done    = 0;
    went_remote = 1'b0;
    while (!op_ack_o && n < timeout_c && timeout_count == 0) begin
      @(negedge clk_i);
      n++;
      if (remote_req_o && !went_remote) begin
        went_remote = 1'b1;
        check_value("cycles from request seen to remote_req_o", n - 1, 2);
        serve_network();
        net_done = n;
      end
    end
    if (!op_ack_o) begin
      if (timeout_count == 0) begin
        report_timeout("op_ack_o never rose for the current operation");
      end
    end else begin
      check_value("remote path taken", went_remote, exp_path);
      if (!exp_path[0]) begin
        check_value("cycles from request seen to op_ack_o", n - 1, 3);
      end else if (went_remote) begin
        check_value("cycles from remote_ack_i release to op_ack_o", n - net_done, 2);
      end
      check_value("load_data_o", load_data_o, exp_load);
      check_value("reserve_valid_o", reserve_valid_o, exp_res);
      op_req_i = 1'b0;
      n = 0;
      while (op_ack_o && n < timeout_c) begin
        @(negedge clk_i);
        n++;
      end
      if (op_ack_o) begin
        report_timeout("op_ack_o never fell after op_req_i dropped");
      end
    end
  endtask

  initial begin
    int                fd;
    int                code;
    logic [63:0]       kind;
    logic [8*160-1:0]  skip_line;
    lsu_pkg::mem_op_s  op;
    lsu_pkg::mem_op_e  op_code;
    logic              kind_ok;
    reset_i        = 1'b0;
    op_req_i       = 1'b0;
    op_i           = '0;
    tg_x_cord_i    = 6'h05;
    tg_y_cord_i    = 5'h03;
    remote_ack_i   = 1'b0;
    remote_rdata_i = '0;
    error_count    = 0;
    timeout_count  = 0;
    vector_count   = 0;
    rng_state      = 32'd48;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b1;
    @(negedge clk_i);
    check_value("op_ack_o after reset", op_ack_o, 1'b0);
    check_value("remote_req_o after reset", remote_req_o, 1'b0);
    check_value("load_data_o after reset", load_data_o, 32'h0);
    check_value("reserve_valid_o after reset", reserve_valid_o, 1'b0);
    fd = $fopen("lsu_testdata.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open lsu_testdata.txt for reading");
    end else begin
      while (!$feof(fd) && timeout_count == 0) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          break;
        end
        if (kind == "#") begin
          code = $fgets(skip_line, fd);
        end else begin
          code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h", rs1, rs2, offset, rd,
                         exp_path, exp_addr, exp_mask, exp_data, net_rdata, exp_load,
                         exp_res);
          if (code != 11) begin
            error_count++;
            $display("malformed vector line in lsu_testdata.txt after %0d vectors",
                     vector_count);
            break;
          end
          decode_kind(kind, op_code, kind_ok);
          if (!kind_ok) begin
            error_count++;
            $display("unknown operation kind %0s in lsu_testdata.txt", kind);
          end else begin
            op.op     = op_code;
            op.rs1    = rs1;
            op.rs2    = rs2;
            op.rd     = rd[lsu_pkg::reg_addr_width_c-1:0];
            op.offset = offset[lsu_pkg::imm_width_c-1:0];
            run_op(op);
            vector_count++;
          end
        end
      end
      $fclose(fd);
    end
    if (vector_count == 0) begin
      error_count++;
      $display("no operation vectors were run");
    end
    $display("vectors: %0d  errors: %0d  timeouts: %0d", vector_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== lsu_testdata.txt ====
# kind rs1 rs2 offset rd path(0 local, 1 remote) addr mask data (remote fields, else 0)
# net_rdata expected_load_data expected_reserve_valid ; tile x=05 y=03
sw 00000100 11223344 000 01 0 00000000 0 00000000 00000000 00000000 0
sh 00000100 0000beef 002 02 0 00000000 0 00000000 00000000 00000000 0
sb 00000100 000000a5 001 03 0 00000000 0 00000000 00000000 00000000 0
lw 00000100 00000000 000 04 0 00000000 0 00000000 00000000 beefa544 0
lh 00000100 00000000 002 05 0 00000000 0 00000000 00000000 ffffbeef 0
lhu 00000100 00000000 002 06 0 00000000 0 00000000 00000000 0000beef 0
lb 00000100 00000000 001 07 0 00000000 0 00000000 00000000 ffffffa5 0
lbu 00000100 00000000 001 08 0 00000000 0 00000000 00000000 000000a5 0
lh 00000104 00000000 ffc 09 0 00000000 0 00000000 00000000 ffffa544 0
sw 23140000 cafef00d 040 0a 0 00000000 0 00000000 00000000 00000000 0
lw 00000000 00000000 040 0b 0 00000000 0 00000000 00000000 cafef00d 0
lbu 23140000 00000000 043 0c 0 00000000 0 00000000 00000000 000000ca 0
sw 00002000 12345678 010 0d 1 00002010 f 12345678 00000000 00000000 0
sb 23180000 0000007e 003 0e 1 23180003 8 7e7e7e7e 00000000 00000000 0
sh 00010000 00001234 006 0f 1 00010006 c 12341234 00000000 00000000 0
lh 00003000 00000000 002 10 1 00003002 c 00000000 80017fff ffff8001 0
lbu 23180000 00000000 001 11 1 23180001 2 00000000 0000ab00 000000ab 0
amoadd 00005000 00000005 000 12 1 00005000 f 00000005 00000010 00000010 0
amoswap 23180000 ffff0001 008 13 1 23180008 f ffff0001 80000000 80000000 0
sw 00000200 0badf00d 000 14 0 00000000 0 00000000 00000000 00000000 0
lr 00000200 00000000 000 15 0 00000000 0 00000000 00000000 0badf00d 1
sw 00000204 00000001 000 16 0 00000000 0 00000000 00000000 00000000 1
sb 00000200 00000077 003 17 0 00000000 0 00000000 00000000 00000000 0
lw 00000200 00000000 000 18 0 00000000 0 00000000 00000000 77adf00d 0

// ==== lsu_tile.f ====
lsu_pkg.sv
lsu.sv
lsu_dmem.sv
load_align.sv
lsu_ctrl.sv
lsu_tile.sv
lsu_tile_tb.sv
